//--- rtl/cache_way.sv
//////////////////////////////////////////////////
// cache way
// one way of every set: tag, valid, dirty, age
// and line data, with store merge and fill
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cache_way
    import dcache_pkg::*;
#(
    parameter int unsigned way_id = 0
) (
    input  logic        clock,
    input  logic        reset,
    input  set_idx_t    set_idx,
    input  tag_t        lookup_tag,
    input  logic        word_sel,
    input  word_t       req_data,
    input  byte_mask_t  req_byte_mask,
    input  line_t       mem_rdata,
    input  logic        store_enable,
    input  logic        fill_enable,
    input  logic        access_enable,
    input  logic        victim,
    input  age_t        touched_age,
    output logic        hit,
    output age_t        age,
    output logic        valid,
    output logic        dirty,
    output tag_t        tag,
    output line_t       line
);

    tag_t                tags  [num_sets];
    line_t               data  [num_sets];
    age_t                ages  [num_sets];
    logic [num_sets-1:0] valid_bits;
    logic [num_sets-1:0] dirty_bits;

    logic store_hit;
    logic fill_here;
    logic touched;

    // addressed entry
    assign valid = valid_bits[set_idx];
    assign dirty = dirty_bits[set_idx];
    assign tag   = tags[set_idx];
    assign line  = data[set_idx];
    assign age   = ages[set_idx];
    assign hit   = valid && (tag == lookup_tag);

    assign store_hit = store_enable && hit;
    assign fill_here = fill_enable && victim;
    // during a fill the victim counts as the touched way
    assign touched   = fill_enable ? victim : hit;

    //////////////////////////////////////////////////
    // control state
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            for (int s = 0; s < num_sets; s++) begin
                ages[s] <= age_t'(way_id);
            end
        end else begin
            if (fill_here) begin
                valid_bits[set_idx] <= 1'b1;
                dirty_bits[set_idx] <= 1'b0;
            end else if (store_hit) begin
                dirty_bits[set_idx] <= 1'b1;
            end
            // age rank update, keeps the set a permutation
            if (access_enable) begin
                if (touched) begin
                    ages[set_idx] <= age_t'(num_ways - 1);
                end else if (age > touched_age) begin
                    ages[set_idx] <= age - 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // tag and line payload
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (fill_here) begin
            tags[set_idx] <= lookup_tag;
            data[set_idx] <= mem_rdata;
        end else if (store_hit) begin
            for (int b = 0; b < word_bits / 8; b++) begin
                if (req_byte_mask[b]) begin
                    data[set_idx][word_sel][8*b +: 8] <= req_data[8*b +: 8];
                end
            end
        end
    end

    // the line being filled is never already present
    assert property (@(posedge clock) disable iff (reset)
        fill_enable |-> !hit);

endmodule

//--- rtl/dcache_pkg.sv
//////////////////////////////////////////////////
// data cache shared definitions
// geometry, address fields, line and enum types
//////////////////////////////////////////////////

package dcache_pkg;

    //////////////////////////////////////////////////
    // geometry
    //////////////////////////////////////////////////

    localparam int unsigned num_ways   = 4;
    localparam int unsigned num_sets   = 4;
    localparam int unsigned addr_bits  = 16;
    localparam int unsigned word_bits  = 32;
    localparam int unsigned line_words = 2;
    localparam int unsigned tag_bits   = 11;
    localparam int unsigned set_bits   = 2;
    localparam int unsigned way_bits   = 2;

    // byte offset inside a word, then the word select bit
    localparam int unsigned word_offset_bits = 2;
    localparam int unsigned line_offset_bits = 3;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef logic [addr_bits-1:0]     addr_t;
    typedef logic [word_bits-1:0]     word_t;
    // word 0 sits at the lower address
    typedef logic [line_words-1:0][word_bits-1:0] line_t;
    typedef logic [word_bits/8-1:0]   byte_mask_t;
    typedef logic [tag_bits-1:0]      tag_t;
    typedef logic [set_bits-1:0]      set_idx_t;
    // 0 is least recently used
    typedef logic [way_bits-1:0]      age_t;
    typedef logic [num_ways-1:0]      way_mask_t;

    // memory side command, held as a level
    typedef enum logic [1:0] {
        mem_idle  = 2'd0,
        mem_read  = 2'd1,
        mem_write = 2'd2
    } mem_cmd_t;

    // controller states
    typedef enum logic [1:0] {
        ctrl_lookup    = 2'd0,
        ctrl_writeback = 2'd1,
        ctrl_fill      = 2'd2
    } ctrl_state_t;

endpackage

//--- rtl/dcache_top.sv
//////////////////////////////////////////////////
// data cache top
// blocking write-back, write-allocate cache
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        req_valid,
    input  logic        req_write,
    input  addr_t       req_addr,
    input  word_t       req_data,
    input  byte_mask_t  req_byte_mask,
    output logic        resp_valid,
    output word_t       resp_data,
    output mem_cmd_t    mem_command,
    output addr_t       mem_addr,
    output line_t       mem_wdata,
    input  logic        mem_response,
    input  line_t       mem_rdata
);

    set_idx_t set_idx;
    tag_t     lookup_tag;
    logic     word_sel;
    logic     store_enable;
    logic     fill_enable;
    logic     access_enable;

    logic     any_hit;
    logic     victim_valid;
    logic     victim_dirty;
    tag_t     victim_tag;
    word_t    hit_word;
    age_t     touched_age;

    // per way buses
    way_mask_t               way_hit;
    way_mask_t               way_valid;
    way_mask_t               way_dirty;
    way_mask_t               way_victim;
    age_t  [num_ways-1:0]    way_age;
    tag_t  [num_ways-1:0]    way_tag;
    line_t [num_ways-1:0]    way_line;

    miss_control u_miss_control (
        .clock         (clock),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .any_hit       (any_hit),
        .victim_valid  (victim_valid),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .hit_word      (hit_word),
        .mem_response  (mem_response),
        .set_idx       (set_idx),
        .lookup_tag    (lookup_tag),
        .word_sel      (word_sel),
        .store_enable  (store_enable),
        .fill_enable   (fill_enable),
        .access_enable (access_enable),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .mem_command   (mem_command),
        .mem_addr      (mem_addr)
    );

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        cache_way #(
            .way_id (w)
        ) u_way (
            .clock         (clock),
            .reset         (reset),
            .set_idx       (set_idx),
            .lookup_tag    (lookup_tag),
            .word_sel      (word_sel),
            .req_data      (req_data),
            .req_byte_mask (req_byte_mask),
            .mem_rdata     (mem_rdata),
            .store_enable  (store_enable),
            .fill_enable   (fill_enable),
            .access_enable (access_enable),
            .victim        (way_victim[w]),
            .touched_age   (touched_age),
            .hit           (way_hit[w]),
            .age           (way_age[w]),
            .valid         (way_valid[w]),
            .dirty         (way_dirty[w]),
            .tag           (way_tag[w]),
            .line          (way_line[w])
        );
    end

    way_select u_way_select (
        .hit          (way_hit),
        .valid        (way_valid),
        .dirty        (way_dirty),
        .age          (way_age),
        .tag          (way_tag),
        .line         (way_line),
        .word_sel     (word_sel),
        .any_hit      (any_hit),
        .hit_word     (hit_word),
        .victim       (way_victim),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (mem_wdata),
        .touched_age  (touched_age)
    );

endmodule

//--- rtl/miss_control.sv
//////////////////////////////////////////////////
// miss control
// decodes the request, answers hits and walks
// the write-back and fill sequence on a miss
//////////////////////////////////////////////////

`timescale 1ns/1ps

module miss_control
    import dcache_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        req_valid,
    input  logic        req_write,
    input  addr_t       req_addr,
    input  logic        any_hit,
    input  logic        victim_valid,
    input  logic        victim_dirty,
    input  tag_t        victim_tag,
    input  word_t       hit_word,
    input  logic        mem_response,
    output set_idx_t    set_idx,
    output tag_t        lookup_tag,
    output logic        word_sel,
    output logic        store_enable,
    output logic        fill_enable,
    output logic        access_enable,
    output logic        resp_valid,
    output word_t       resp_data,
    output mem_cmd_t    mem_command,
    output addr_t       mem_addr
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        in_lookup;

    //////////////////////////////////////////////////
    // request decode
    //////////////////////////////////////////////////

    assign set_idx    = req_addr[line_offset_bits +: set_bits];
    assign lookup_tag = req_addr[addr_bits-1 -: tag_bits];
    assign word_sel   = req_addr[word_offset_bits];

    assign in_lookup = (state == ctrl_lookup);

    // hits answer in the same cycle
    assign resp_valid = in_lookup && req_valid && any_hit;
    assign resp_data  = hit_word;

    // ways only merge when they hit themselves
    assign store_enable  = in_lookup && req_valid && req_write;
    assign fill_enable   = (state == ctrl_fill) && mem_response;
    assign access_enable = resp_valid || fill_enable;

    //////////////////////////////////////////////////
    // memory side
    //////////////////////////////////////////////////

    always_comb begin
        mem_command = mem_idle;
        // default to the requested line, used by the fill
        mem_addr    = {lookup_tag, set_idx, {line_offset_bits{1'b0}}};
        case (state)
            ctrl_writeback: begin
                mem_command = mem_write;
                mem_addr    = {victim_tag, set_idx, {line_offset_bits{1'b0}}};
            end
            ctrl_fill: begin
                mem_command = mem_read;
            end
            default: begin
                mem_command = mem_idle;
            end
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            ctrl_lookup: begin
                if (req_valid && !any_hit) begin
                    if (victim_valid && victim_dirty) begin
                        state_next = ctrl_writeback;
                    end else begin
                        state_next = ctrl_fill;
                    end
                end
            end
            ctrl_writeback: begin
                if (mem_response) begin
                    state_next = ctrl_fill;
                end
            end
            ctrl_fill: begin
                // the retried lookup hits on the next cycle
                if (mem_response) begin
                    state_next = ctrl_lookup;
                end
            end
            default: begin
                state_next = ctrl_lookup;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ctrl_lookup;
        end else begin
            state <= state_next;
        end
    end

    // a finished fill is answered by the retried lookup
    assert property (@(posedge clock) disable iff (reset)
        fill_enable |=> resp_valid);

endmodule

//--- rtl/way_select.sv
//////////////////////////////////////////////////
// way select
// merges the ways into hit data, the LRU victim
// and the age of the touched way
//////////////////////////////////////////////////

`timescale 1ns/1ps

module way_select
    import dcache_pkg::*;
(
    input  way_mask_t               hit,
    input  way_mask_t               valid,
    input  way_mask_t               dirty,
    input  age_t  [num_ways-1:0]    age,
    input  tag_t  [num_ways-1:0]    tag,
    input  line_t [num_ways-1:0]    line,
    input  logic                    word_sel,
    output logic                    any_hit,
    output word_t                   hit_word,
    output way_mask_t               victim,
    output logic                    victim_valid,
    output logic                    victim_dirty,
    output tag_t                    victim_tag,
    output line_t                   victim_line,
    output age_t                    touched_age
);

    logic [way_bits-1:0] victim_idx;

    assign any_hit = |hit;

    // hit side, at most one way contributes
    always_comb begin
        hit_word    = '0;
        touched_age = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit[w]) begin
                hit_word    = line[w][word_sel];
                touched_age = age[w];
            end
        end
    end

    // scan downward so the lowest age 0 way wins
    always_comb begin
        victim_idx = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (age[w] == '0) begin
                victim_idx = w[way_bits-1:0];
            end
        end
    end

    assign victim       = way_mask_t'(1) << victim_idx;
    assign victim_valid = valid[victim_idx];
    assign victim_dirty = dirty[victim_idx];
    assign victim_tag   = tag[victim_idx];
    assign victim_line  = line[victim_idx];

    // a tag is never present in two ways of a set
    always_comb begin
        assert final ($onehot0(hit));
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the data cache testbench with Verilator and run it
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module dcache_tb -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

//--- sim/dcache_tb.sv
//////////////////////////////////////////////////
// data cache testbench
// directed tests against a reference memory
// and an LRU model of every set
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int    clock_period = 40;
    localparam int    wait_limit   = 200;
    localparam int    seed_start   = 15202;
    localparam word_t fill_base    = 32'h3c00_0000;

    logic       clock;
    logic       reset;
    logic       req_valid;
    logic       req_write;
    addr_t      req_addr;
    word_t      req_data;
    byte_mask_t req_byte_mask;
    logic       resp_valid;
    word_t      resp_data;
    mem_cmd_t   mem_command;
    addr_t      mem_addr;
    line_t      mem_wdata;
    logic       mem_response;
    line_t      mem_rdata;

    int    mem_reads;
    int    mem_writes;
    addr_t last_read_addr;
    addr_t last_write_addr;
    line_t last_write_data;

    // reference state, keyed by word address
    word_t ref_words [addr_t];
    tag_t  model_tag   [num_sets][num_ways];
    age_t  model_age   [num_sets][num_ways];
    logic  model_valid [num_sets][num_ways];
    logic  model_dirty [num_sets][num_ways];

    int seed;
    int error_count;
    int check_count;

    dcache_top DUT (
        .clock         (clock),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_data      (req_data),
        .req_byte_mask (req_byte_mask),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .mem_command   (mem_command),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_response  (mem_response),
        .mem_rdata     (mem_rdata)
    );

    mem_model #(
        .fill_base  (fill_base),
        .seed_start (seed_start)
    ) u_mem (
        .clock           (clock),
        .reset           (reset),
        .mem_command     (mem_command),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_response    (mem_response),
        .mem_rdata       (mem_rdata),
        .read_count      (mem_reads),
        .write_count     (mem_writes),
        .last_read_addr  (last_read_addr),
        .last_write_addr (last_write_addr),
        .last_write_data (last_write_data)
    );

    initial clock = 1'b0;
    always #(clock_period / 2) clock = ~clock;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // word k of a line is line address times 4 plus k plus a base
    function automatic word_t initial_word(addr_t addr);
        addr_t line_addr;
        line_addr = {addr[addr_bits-1:3], 3'b000};
        return {16'h0, line_addr} * 4 + word_t'(addr[2]) + fill_base;
    endfunction

    function automatic word_t ref_word(addr_t addr);
        addr_t key;
        key = {addr[addr_bits-1:2], 2'b00};
        if (ref_words.exists(key)) begin
            return ref_words[key];
        end
        return initial_word(key);
    endfunction

    function automatic word_t merge_bytes(word_t old_word, word_t new_word, byte_mask_t mask);
        word_t result;
        result = old_word;
        for (int b = 0; b < word_bits / 8; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic reset_model();
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
                model_tag[s][w]   = '0;
                model_age[s][w]   = age_t'(w);
            end
        end
    endtask

    // touched way becomes youngest, younger ways move down one
    task automatic touch_way(set_idx_t set_index, int way);
        age_t old_age;
        old_age = model_age[set_index][way];
        for (int w = 0; w < num_ways; w++) begin
            if (w == way) begin
                model_age[set_index][w] = age_t'(num_ways - 1);
            end else if (model_age[set_index][w] > old_age) begin
                model_age[set_index][w] = model_age[set_index][w] - 1'b1;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // checking and requests
    //////////////////////////////////////////////////

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic run_access(logic write, addr_t addr, word_t data, byte_mask_t mask);
        set_idx_t set_index;
        tag_t     tag;
        int       way;
        int       cycles;
        int       reads_before;
        int       writes_before;
        logic     hit;
        logic     write_back;
        addr_t    victim_addr;
        line_t    victim_data;
        word_t    expected;

        set_index   = addr[4:3];
        tag         = addr[addr_bits-1:5];
        way         = -1;
        write_back  = 1'b0;
        victim_addr = '0;
        victim_data = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (model_valid[set_index][w] && model_tag[set_index][w] == tag) begin
                way = w;
            end
        end
        hit = (way >= 0);
        if (!hit) begin
            // lowest numbered way of age 0 is the victim
            for (int w = num_ways - 1; w >= 0; w--) begin
                if (model_age[set_index][w] == '0) begin
                    way = w;
                end
            end
            write_back     = model_valid[set_index][way] && model_dirty[set_index][way];
            victim_addr    = {model_tag[set_index][way], set_index, 3'b000};
            victim_data[0] = ref_word(victim_addr);
            victim_data[1] = ref_word(victim_addr + 16'd4);
        end
        expected      = ref_word(addr);
        reads_before  = mem_reads;
        writes_before = mem_writes;

        @(negedge clock);
        req_valid     = 1'b1;
        req_write     = write;
        req_addr      = addr;
        req_data      = data;
        req_byte_mask = mask;
        cycles        = 0;
        #(clock_period / 4);
        while (!resp_valid && cycles < wait_limit) begin
            @(negedge clock);
            #(clock_period / 4);
            cycles++;
        end

        if (!resp_valid) begin
            error_count++;
            $display("timeout: no response to the request at address %h", addr);
            finish_run();
        end else begin
            if (!write) begin
                check_value("resp_data", 64'(expected), 64'(resp_data));
            end
            @(negedge clock);
            req_valid = 1'b0;
            if (hit) begin
                check_value("hit_cycles", 64'(0), 64'(cycles));
                check_value("mem_reads", 64'(reads_before), 64'(mem_reads));
            end else begin
                check_value("mem_reads", 64'(reads_before + 1), 64'(mem_reads));
                check_value("mem_addr", 64'({addr[addr_bits-1:3], 3'b000}),
                    64'(last_read_addr));
                model_tag[set_index][way]   = tag;
                model_valid[set_index][way] = 1'b1;
                model_dirty[set_index][way] = 1'b0;
            end
            check_value("mem_writes", 64'(writes_before + int'(write_back)), 64'(mem_writes));
            if (write_back) begin
                check_value("mem_addr", 64'(victim_addr), 64'(last_write_addr));
                check_value("mem_wdata", 64'(victim_data), 64'(last_write_data));
            end
            touch_way(set_index, way);
            if (write) begin
                model_dirty[set_index][way] = 1'b1;
                ref_words[{addr[addr_bits-1:2], 2'b00}] = merge_bytes(expected, data, mask);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    // a load presented in the last reset cycle finds every line invalid
    task automatic reset_state();
        @(negedge clock);
        req_valid = 1'b1;
        req_addr  = 16'h0100;
        #(clock_period / 4);
        check_value("resp_valid", 64'(1'b0), 64'(resp_valid));
        check_value("mem_command", 64'(mem_idle), 64'(mem_command));
        @(negedge clock);
        reset     = 1'b0;
        req_valid = 1'b0;
    endtask

    task automatic load_miss_then_hit();
        run_access(1'b0, 16'h0100, '0, '0);
        // other word of the same line hits
        run_access(1'b0, 16'h0104, '0, '0);
    endtask

    task automatic store_on_hit();
        run_access(1'b1, 16'h0100, 32'hdead_beef, 4'b0101);
        run_access(1'b0, 16'h0100, '0, '0);
    endtask

    task automatic store_on_miss();
        run_access(1'b1, 16'h020c, 32'h1234_5678, 4'b0110);
        run_access(1'b0, 16'h020c, '0, '0);
        run_access(1'b0, 16'h0208, '0, '0);
    endtask

    task automatic evict_and_write_back();
        // five lines of set 2, the first one dirty
        run_access(1'b1, 16'h1010, 32'hcafe_0001, 4'b1111);
        run_access(1'b1, 16'h1034, 32'hcafe_0002, 4'b1100);
        run_access(1'b0, 16'h1050, '0, '0);
        run_access(1'b0, 16'h1070, '0, '0);
        run_access(1'b0, 16'h1090, '0, '0);
        check_value("evicted_line", 64'(16'h1010), 64'(last_write_addr));
        run_access(1'b0, 16'h1010, '0, '0);
    endtask

    task automatic random_mix();
        int    r;
        word_t data;
        for (int n = 0; n < 200; n++) begin
            r    = $random(seed);
            data = $random(seed);
            // 32 lines, eight per set
            run_access(r[6], {8'h40, r[4:0], r[5], 2'b00}, data, r[10:7]);
        end
    endtask

    initial begin
        seed          = seed_start;
        error_count   = 0;
        check_count   = 0;
        reset         = 1'b1;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_addr      = '0;
        req_data      = '0;
        req_byte_mask = '0;
        reset_model();
        // reset_state covers the tenth reset cycle and releases reset
        repeat (9) @(posedge clock);

        reset_state();
        load_miss_then_hit();
        store_on_hit();
        store_on_miss();
        evict_and_write_back();
        random_mix();
        finish_run();
    end

endmodule

//--- sim/mem_model.sv
//////////////////////////////////////////////////
// backing memory model
// line addressed, answers each held command once
// after a random latency
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_model
    import dcache_pkg::*;
#(
    parameter word_t fill_base  = 32'h3c00_0000,
    parameter int    seed_start = 15202
) (
    input  logic     clock,
    input  logic     reset,
    input  mem_cmd_t mem_command,
    input  addr_t    mem_addr,
    input  line_t    mem_wdata,
    output logic     mem_response,
    output line_t    mem_rdata,
    output int       read_count,
    output int       write_count,
    output addr_t    last_read_addr,
    output addr_t    last_write_addr,
    output line_t    last_write_data
);

    // only lines that were written are stored
    line_t lines [addr_t];
    logic  busy;
    int    wait_cycles;
    int    seed = seed_start;

    // untouched lines follow the initial content rule
    function automatic line_t line_at(addr_t line_addr);
        line_t value;
        if (lines.exists(line_addr)) begin
            value = lines[line_addr];
        end else begin
            for (int k = 0; k < line_words; k++) begin
                value[k] = {16'h0, line_addr} * 4 + word_t'(k) + fill_base;
            end
        end
        return value;
    endfunction

    always @(posedge clock) begin
        mem_response <= 1'b0;
        if (reset) begin
            busy        <= 1'b0;
            wait_cycles <= 0;
            read_count  <= 0;
            write_count <= 0;
        end else if (busy) begin
            if (wait_cycles == 0) begin
                busy         <= 1'b0;
                mem_response <= 1'b1;
                if (mem_command == mem_write) begin
                    lines[mem_addr] = mem_wdata;
                end else begin
                    mem_rdata <= line_at(mem_addr);
                end
            end else begin
                wait_cycles <= wait_cycles - 1;
            end
        end else if (mem_command != mem_idle && !mem_response) begin
            // a command still held in the response cycle is already served
            busy        <= 1'b1;
            wait_cycles <= 1 + int'($unsigned($random(seed)) % 6);
            if (mem_command == mem_write) begin
                write_count     <= write_count + 1;
                last_write_addr <= mem_addr;
                last_write_data <= mem_wdata;
            end else begin
                read_count     <= read_count + 1;
                last_read_addr <= mem_addr;
            end
        end
    end

endmodule

//--- tb.f
rtl/dcache_pkg.sv
rtl/miss_control.sv
rtl/cache_way.sv
rtl/way_select.sv
rtl/dcache_top.sv
sim/mem_model.sv
sim/dcache_tb.sv
